// File: src/aim_config.svh
`ifndef AIM_CONFIG_SVH
`define AIM_CONFIG_SVH

// Active frame size.
`define AIM_H_ACT     1280
`define AIM_V_ACT     720

`define AIM_N_BOX     2
`define AIM_BOX_BYTES 6   // Payload bytes per box.
`define AIM_BORDER    2   // Border thickness in pixels.

`endif

// File: src/aim_pkg.sv
`include "aim_config.svh"

package aim_pkg;

    localparam int X_W       = $clog2(`AIM_H_ACT);  // 11 bits.
    localparam int Y_W       = $clog2(`AIM_V_ACT);  // 10 bits.
    localparam int PAY_BYTES = `AIM_N_BOX * `AIM_BOX_BYTES;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef enum logic [1:0] {
        red,
        green,
        blue,
        yellow
    } box_color_e;

    typedef struct packed {
        logic           enable;
        box_color_e     color;
        logic [X_W-1:0] start_x;
        logic [Y_W-1:0] start_y;
        logic [X_W-1:0] end_x;
        logic [Y_W-1:0] end_y;
    } box_t;

    typedef enum logic {
        show_cam1,
        show_cam2
    } sel_state_e;

    // Byte PAY_BYTES-1 holds the first byte received.
    typedef logic [PAY_BYTES-1:0][7:0] payload_t;

    function automatic logic [23:0] color_rgb(box_color_e code);
        case (code)
            red:     return 24'hFF0000;
            green:   return 24'h00FF00;
            blue:    return 24'h0000FF;
            default: return 24'hFFFF00;
        endcase
    endfunction

endpackage

// File: src/aim_ifs.sv
`include "aim_config.svh"

// One pixel per cycle, no back-pressure.
interface pix_if;
    import aim_pkg::*;

    pixel_t pix;

    modport src (output pix);
    modport dst (input  pix);
endinterface

// Decoded boxes plus a one-cycle strobe on each new set.
interface box_if;
    import aim_pkg::*;

    box_t [`AIM_N_BOX-1:0] boxes;
    logic                  update;

    modport dec (
        output boxes,
        output update
    );
    modport ovl (
        input  boxes,
        input  update
    );
endinterface

// File: src/udp_reader.sv
module udp_reader (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_rx_valid,
    input  logic [7:0]        i_rx_data,
    output logic              o_filled,
    output aim_pkg::payload_t o_payload
);
    import aim_pkg::*;

    localparam int               CNT_W = $clog2(PAY_BYTES + 1);
    localparam logic [CNT_W-1:0] FULL  = CNT_W'(PAY_BYTES);

    logic [CNT_W-1:0] cnt;
    logic             over;   // Run went past capacity.

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt      <= '0;
            over     <= 1'b0;
            o_filled <= 1'b0;
        end else begin
            // First idle cycle after a run still sees its count.
            o_filled <= !i_rx_valid && (cnt == FULL) && !over;
            if (i_rx_valid) begin
                if (cnt == FULL)
                    over <= 1'b1;
                else
                    cnt <= cnt + 1'b1;
            end else begin
                cnt  <= '0;
                over <= 1'b0;
            end
        end
    end

    // Oldest byte shifts toward the top.
    always_ff @(posedge i_clk) begin
        if (i_rx_valid && (cnt != FULL))
            o_payload <= {o_payload[PAY_BYTES-2:0], i_rx_data};
    end

endmodule

// File: src/box_decoder.sv
`include "aim_config.svh"

module box_decoder (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_filled,
    input  aim_pkg::payload_t i_payload,
    box_if.dec                o_boxes
);
    import aim_pkg::*;

    localparam int BOX_W = `AIM_BOX_BYTES * 8;

    box_t [`AIM_N_BOX-1:0] boxes_dec;
    box_t [`AIM_N_BOX-1:0] boxes_q;
    logic                  update_q;

    always_comb begin : unpack
        logic [BOX_W-1:0] raw;
        for (int i = 0; i < `AIM_N_BOX; i++) begin
            raw = i_payload[PAY_BYTES-1-i*`AIM_BOX_BYTES -: `AIM_BOX_BYTES];
            boxes_dec[i].enable = raw[BOX_W-1];
            boxes_dec[i].color  = box_color_e'(raw[BOX_W-2 -: 2]);
            // Three spare bits sit between the color and the coordinates.
            {boxes_dec[i].start_x, boxes_dec[i].start_y,
             boxes_dec[i].end_x,   boxes_dec[i].end_y} = raw[2*(X_W+Y_W)-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            boxes_q  <= '0;   // All boxes disabled.
            update_q <= 1'b0;
        end else begin
            update_q <= i_filled;
            if (i_filled)
                boxes_q <= boxes_dec;
        end
    end

    assign o_boxes.boxes  = boxes_q;
    assign o_boxes.update = update_q;

endmodule

// File: src/box_overlay.sv
`include "aim_config.svh"

module box_overlay (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_draw_en,
    box_if.ovl   i_boxes,
    pix_if.dst   i_pix,
    pix_if.src   o_pix
);
    import aim_pkg::*;

    localparam logic [X_W-1:0] BORDER_X = X_W'(`AIM_BORDER);
    localparam logic [Y_W-1:0] BORDER_Y = Y_W'(`AIM_BORDER);

    pixel_t                pix_in;
    logic [X_W-1:0]        x_cnt;
    logic [Y_W-1:0]        y_cnt;
    logic                  de_q;
    logic                  vsync_q;
    logic                  frame_start;
    logic                  pend;     // New boxes waiting for a frame start.
    box_t [`AIM_N_BOX-1:0] shadow;
    logic                  hit;
    logic [23:0]           hit_rgb;
    logic [2:0]            ctrl_q;
    logic [23:0]           rgb_q;

    function automatic logic on_border(box_t bx, logic [X_W-1:0] x, logic [Y_W-1:0] y);
        logic in_x;
        logic in_y;
        logic near_x;
        logic near_y;
        in_x   = (x >= bx.start_x) && (x <= bx.end_x);
        in_y   = (y >= bx.start_y) && (y <= bx.end_y);
        // Differences only matter once inside the box.
        near_x = ((x - bx.start_x) < BORDER_X) || ((bx.end_x - x) < BORDER_X);
        near_y = ((y - bx.start_y) < BORDER_Y) || ((bx.end_y - y) < BORDER_Y);
        return bx.enable && in_x && in_y && (near_x || near_y);
    endfunction

    assign pix_in      = i_pix.pix;
    assign frame_start = pix_in.vsync && !vsync_q;

    // Pixel position of the current input.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_cnt   <= '0;
            y_cnt   <= '0;
            de_q    <= 1'b0;
            vsync_q <= 1'b0;
        end else begin
            de_q    <= pix_in.de;
            vsync_q <= pix_in.vsync;
            if (pix_in.de)
                x_cnt <= x_cnt + 1'b1;
            else if (de_q)
                x_cnt <= '0;
            if (pix_in.vsync)
                y_cnt <= '0;
            else if (de_q && !pix_in.de)
                y_cnt <= y_cnt + 1'b1;   // End of an active line.
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pend   <= 1'b0;
            shadow <= '0;
        end else begin
            if (frame_start && (pend || i_boxes.update)) begin
                shadow <= i_boxes.boxes;
                pend   <= 1'b0;
            end else if (i_boxes.update) begin
                pend <= 1'b1;
            end
        end
    end

    // Walk downward so the lowest index wins.
    always_comb begin
        hit     = 1'b0;
        hit_rgb = '0;
        for (int i = `AIM_N_BOX - 1; i >= 0; i--) begin
            if (on_border(shadow[i], x_cnt, y_cnt)) begin
                hit     = 1'b1;
                hit_rgb = color_rgb(shadow[i].color);
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            ctrl_q <= '0;
        else
            ctrl_q <= {pix_in.hsync, pix_in.vsync, pix_in.de};
    end

    always_ff @(posedge i_clk) begin
        if (i_draw_en && pix_in.de && hit)
            rgb_q <= hit_rgb;
        else
            rgb_q <= {pix_in.r, pix_in.g, pix_in.b};
    end

    assign o_pix.pix = {ctrl_q, rgb_q};

endmodule

// File: src/pack_select.sv
module pack_select (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  logic            i_cam_switch,
    pix_if.dst              i_cam1,
    pix_if.dst              i_cam2,
    output aim_pkg::pixel_t o_pix
);
    import aim_pkg::*;

    sel_state_e  state;
    sel_state_e  state_nxt;
    logic        vs1_q;
    logic        vs2_q;
    logic        vs_rise;
    pixel_t      pix_sel;
    logic [2:0]  ctrl_q;
    logic [23:0] rgb_q;

    always_comb begin
        case (state)
            show_cam1: vs_rise = i_cam1.pix.vsync && !vs1_q;
            default:   vs_rise = i_cam2.pix.vsync && !vs2_q;
        endcase
        state_nxt = state;
        if (vs_rise)
            state_nxt = i_cam_switch ? show_cam2 : show_cam1;
        // New source starts with its own vsync pixel.
        pix_sel = (state_nxt == show_cam1) ? i_cam1.pix : i_cam2.pix;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= show_cam1;
            vs1_q  <= 1'b0;
            vs2_q  <= 1'b0;
            ctrl_q <= '0;
        end else begin
            state  <= state_nxt;
            vs1_q  <= i_cam1.pix.vsync;
            vs2_q  <= i_cam2.pix.vsync;
            ctrl_q <= {pix_sel.hsync, pix_sel.vsync, pix_sel.de};
        end
    end

    always_ff @(posedge i_clk) begin
        rgb_q <= {pix_sel.r, pix_sel.g, pix_sel.b};
    end

    assign o_pix = {ctrl_q, rgb_q};

endmodule

// File: src/aim_overlay_top.sv
module aim_overlay_top (
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_cam_switch,
    input  logic       i_draw_switch,
    input  logic       i_rx_valid,
    input  logic [7:0] i_rx_data,

    input  logic       i_cam1_hsync,
    input  logic       i_cam1_vsync,
    input  logic       i_cam1_de,
    input  logic [7:0] i_cam1_r,
    input  logic [7:0] i_cam1_g,
    input  logic [7:0] i_cam1_b,

    input  logic       i_cam2_hsync,
    input  logic       i_cam2_vsync,
    input  logic       i_cam2_de,
    input  logic [7:0] i_cam2_r,
    input  logic [7:0] i_cam2_g,
    input  logic [7:0] i_cam2_b,

    output logic       o_hdmi_hsync,
    output logic       o_hdmi_vsync,
    output logic       o_hdmi_de,
    output logic [7:0] o_hdmi_r,
    output logic [7:0] o_hdmi_g,
    output logic [7:0] o_hdmi_b,

    output logic       o_udp_filled
);
    import aim_pkg::*;

    payload_t udp_payload;
    pixel_t   hdmi_pix;

    pix_if cam1_in  ();
    pix_if cam2_in  ();
    pix_if cam1_out ();
    pix_if cam2_out ();
    box_if boxes    ();

    assign cam1_in.pix = {i_cam1_hsync, i_cam1_vsync, i_cam1_de, i_cam1_r, i_cam1_g, i_cam1_b};
    assign cam2_in.pix = {i_cam2_hsync, i_cam2_vsync, i_cam2_de, i_cam2_r, i_cam2_g, i_cam2_b};

    udp_reader u_udp_reader (
        .i_clk     (i_clk       ),
        .i_arst_n  (i_arst_n    ),
        .i_rx_valid(i_rx_valid  ),
        .i_rx_data (i_rx_data   ),
        .o_filled  (o_udp_filled),
        .o_payload (udp_payload )
    );

    box_decoder u_box_decoder (
        .i_clk    (i_clk       ),
        .i_arst_n (i_arst_n    ),
        .i_filled (o_udp_filled),
        .i_payload(udp_payload ),
        .o_boxes  (boxes       )
    );

    // Both cameras share one box set.
    box_overlay u_cam1_overlay (
        .i_clk    (i_clk        ),
        .i_arst_n (i_arst_n     ),
        .i_draw_en(i_draw_switch),
        .i_boxes  (boxes        ),
        .i_pix    (cam1_in      ),
        .o_pix    (cam1_out     )
    );

    box_overlay u_cam2_overlay (
        .i_clk    (i_clk        ),
        .i_arst_n (i_arst_n     ),
        .i_draw_en(i_draw_switch),
        .i_boxes  (boxes        ),
        .i_pix    (cam2_in      ),
        .o_pix    (cam2_out     )
    );

    pack_select u_pack_select (
        .i_clk       (i_clk       ),
        .i_arst_n    (i_arst_n    ),
        .i_cam_switch(i_cam_switch),
        .i_cam1      (cam1_out    ),
        .i_cam2      (cam2_out    ),
        .o_pix       (hdmi_pix    )
    );

    assign {o_hdmi_hsync, o_hdmi_vsync, o_hdmi_de, o_hdmi_r, o_hdmi_g, o_hdmi_b} = hdmi_pix;

endmodule

// File: tests/tb_clock.sv
module tb_clock (
    output logic o_clk
);
    initial o_clk = 1'b0;

    always #2 o_clk = ~o_clk;   // Period of 4.

endmodule

// File: tests/aim_props.sv
module aim_props #(
    parameter bit SEL_SIDE = 1'b0   // Set when bound to the selector.
) (
    input logic       i_clk,
    input logic       i_arst_n,
    input logic       i_filled,
    input logic       i_state,
    input logic       i_vs_rise,
    input logic [2:0] i_ctrl
);

    if (!SEL_SIDE) begin : g_reader
        filled_one_cycle : assert property (
            @(posedge i_clk) disable iff (!i_arst_n) i_filled |=> !i_filled
        ) else $error("o_filled held high for more than one cycle");
    end else begin : g_select
        state_on_vsync : assert property (
            @(posedge i_clk) disable iff (!i_arst_n) !$past(i_vs_rise) |-> $stable(i_state)
        ) else $error("selector state changed away from a vsync edge");

        ctrl_low_in_reset : assert property (
            @(posedge i_clk) !i_arst_n |-> (i_ctrl == 3'b000)
        ) else $error("output controls not low during reset");
    end

endmodule

// File: tests/tb_aim_overlay.sv
`include "aim_config.svh"

module tb_aim_overlay;
    import aim_pkg::*;

    localparam int MAX_LINES = 64;

    logic       clk, arst_n, cam_sw, draw_sw, rx_valid;
    logic [7:0] rx_data;
    logic       c1_hs, c1_vs, c1_de, c2_hs, c2_vs, c2_de;
    logic [7:0] c1_r, c1_g, c1_b, c2_r, c2_g, c2_b;
    logic       h_hs, h_vs, h_de, udp_filled;
    logic [7:0] h_r, h_g, h_b;
    pixel_t     dut_pix;

    byte          kind_a [MAX_LINES];
    logic [127:0] name_a [MAX_LINES];
    int           arg_a  [MAX_LINES][5];
    logic [7:0]   byte_a [MAX_LINES][14];
    int           n_lines, n_mismatch, n_other, fills, painted, mid_idx;
    logic [127:0] cur_name;
    logic [31:0]  rng;
    logic         sel, vs_last, pend, cam_drv, draw_drv;
    box_t         act [`AIM_N_BOX];
    box_t         pend_b [`AIM_N_BOX];
    pixel_t       exp_q [$];
    pixel_t       src_q [$];
    logic [7:0]   rx_q [$];

    tb_clock u_clock (.o_clk(clk));

    aim_overlay_top dut (
        .i_clk(clk), .i_arst_n(arst_n), .i_cam_switch(cam_sw), .i_draw_switch(draw_sw),
        .i_rx_valid(rx_valid), .i_rx_data(rx_data),
        .i_cam1_hsync(c1_hs), .i_cam1_vsync(c1_vs), .i_cam1_de(c1_de),
        .i_cam1_r(c1_r), .i_cam1_g(c1_g), .i_cam1_b(c1_b),
        .i_cam2_hsync(c2_hs), .i_cam2_vsync(c2_vs), .i_cam2_de(c2_de),
        .i_cam2_r(c2_r), .i_cam2_g(c2_g), .i_cam2_b(c2_b),
        .o_hdmi_hsync(h_hs), .o_hdmi_vsync(h_vs), .o_hdmi_de(h_de),
        .o_hdmi_r(h_r), .o_hdmi_g(h_g), .o_hdmi_b(h_b), .o_udp_filled(udp_filled)
    );

    bind udp_reader aim_props u_props (.i_clk, .i_arst_n, .i_filled(o_filled),
        .i_state(1'b0), .i_vs_rise(1'b0), .i_ctrl(3'b000));
    bind pack_select aim_props #(.SEL_SIDE(1'b1)) u_props (.i_clk, .i_arst_n,
        .i_filled(1'b0), .i_state(state), .i_vs_rise(vs_rise), .i_ctrl(o_pix[26:24]));

    assign dut_pix = {h_hs, h_vs, h_de, h_r, h_g, h_b};

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [23:0] palette(logic [1:0] code);
        case (code)
            2'd0:    return 24'hFF0000;
            2'd1:    return 24'h00FF00;
            2'd2:    return 24'h0000FF;
            default: return 24'hFFFF00;
        endcase
    endfunction

    // Six bytes, MSB first: enable, code, 3 spare bits, then four coordinates.
    function automatic box_t box_from_bytes(int line, int base);
        logic [47:0] raw;
        box_t        bx;
        for (int i = 0; i < 6; i++)
            raw[47-8*i -: 8] = byte_a[line][base+i];
        bx.enable  = raw[47];
        bx.color   = box_color_e'(raw[46:45]);
        bx.start_x = raw[41:31];
        bx.start_y = raw[30:21];
        bx.end_x   = raw[20:10];
        bx.end_y   = raw[9:0];
        return bx;
    endfunction

    function automatic logic on_edge(box_t bx, int x, int y);
        int sx, sy, ex, ey;
        sx = int'(bx.start_x);
        sy = int'(bx.start_y);
        ex = int'(bx.end_x);
        ey = int'(bx.end_y);
        if (!bx.enable || x < sx || x > ex || y < sy || y > ey)
            return 1'b0;
        return (x - sx < `AIM_BORDER) || (ex - x < `AIM_BORDER) ||
               (y - sy < `AIM_BORDER) || (ey - y < `AIM_BORDER);
    endfunction

    task automatic check_pixel(logic [127:0] name, pixel_t exp, pixel_t got);
        if (got !== exp) begin
            n_mismatch++;
            $display("mismatch %0s pixel expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic check_filled(logic [127:0] name, logic exp, logic got);
        if (got !== exp) begin
            n_mismatch++;
            $display("mismatch %0s filled expected %b actual %b", name, exp, got);
        end
    endtask

    task automatic check_count(logic [127:0] name, int exp, int got);
        if (got != exp) begin
            n_mismatch++;
            $display("mismatch %0s painted expected %0d actual %0d", name, exp, got);
        end
    endtask

    task automatic queue_packet(int line);
        fills    = 0;
        cur_name = name_a[line];
        for (int i = 0; i < arg_a[line][0]; i++)
            rx_q.push_back(byte_a[line][i]);
        if (arg_a[line][0] == `AIM_BOX_BYTES * `AIM_N_BOX) begin
            pend = 1'b1;
            for (int b = 0; b < `AIM_N_BOX; b++)
                pend_b[b] = box_from_bytes(line, b * `AIM_BOX_BYTES);
        end
    endtask

    task automatic close_packet(int line);
        check_filled(name_a[line], arg_a[line][1] != 0, fills != 0);
        if (fills > 1) begin
            n_other++;
            $display("%0s: the fill pulse came more than once", name_a[line]);
        end
    endtask

    // One clock of stimulus, with the model output queued for two cycles later.
    task automatic step(logic hs, logic vs, logic de, int x, int y);
        pixel_t p1, p2, e, src;
        logic [23:0] col;
        logic paint;
        @(posedge clk);
        #1;
        if (exp_q.size() == 2) begin
            e   = exp_q.pop_front();
            src = src_q.pop_front();
            check_pixel(cur_name, e, dut_pix);
            if (dut_pix.de && dut_pix[23:0] !== src[23:0])
                painted++;   // Recolored by the DUT.
        end
        if (udp_filled)
            fills++;
        rng = xorshift(rng);
        p1  = {hs, vs, de, rng[23:0]};
        rng = xorshift(rng);
        p2  = {hs, vs, de, rng[23:0]};
        {c1_hs, c1_vs, c1_de, c1_r, c1_g, c1_b} = p1;
        {c2_hs, c2_vs, c2_de, c2_r, c2_g, c2_b} = p2;
        rx_valid = rx_q.size() != 0;
        rx_data  = rx_valid ? rx_q.pop_front() : 8'h00;
        cam_sw   = cam_drv;
        draw_sw  = draw_drv;
        if (vs && !vs_last) begin
            sel = cam_drv;
            if (pend) begin
                act  = pend_b;
                pend = 1'b0;
            end
        end
        vs_last = vs;
        paint   = 1'b0;
        col     = '0;
        for (int b = `AIM_N_BOX - 1; b >= 0; b--) begin
            if (on_edge(act[b], x, y)) begin
                paint = 1'b1;
                col   = palette(act[b].color);
            end
        end
        src_q.push_back(sel ? p2 : p1);
        if (draw_drv && de && paint) begin
            p1[23:0] = col;
            p2[23:0] = col;
        end
        e = sel ? p2 : p1;
        exp_q.push_back(e);
    endtask

    task automatic run_frame(int line);
        cur_name = name_a[line];
        draw_drv = arg_a[line][3][0];
        painted  = 0;
        repeat (2) step(1'b0, 1'b1, 1'b0, 0, 0);
        repeat (2) step(1'b0, 1'b0, 1'b0, 0, 0);
        for (int y = 0; y < arg_a[line][1]; y++) begin
            if (y == 0) begin
                cam_drv = arg_a[line][2][0];   // Switch moves mid-frame.
                if (mid_idx >= 0)
                    queue_packet(mid_idx);
            end
            for (int x = 0; x < arg_a[line][0]; x++)
                step(1'b0, 1'b0, 1'b1, x, y);
            step(1'b1, 1'b0, 1'b0, 0, 0);
            repeat (2) step(1'b0, 1'b0, 1'b0, 0, 0);
        end
        repeat (4) step(1'b0, 1'b0, 1'b0, 0, 0);
        check_count(name_a[line], arg_a[line][4], painted);
        if (mid_idx >= 0)
            close_packet(mid_idx);
        mid_idx = -1;
    endtask

    task automatic read_vectors(int fd);
        string line;
        int    b [14];
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) == "P") begin
                void'($sscanf(line, "P %s %d %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name_a[n_lines], arg_a[n_lines][0], arg_a[n_lines][1], arg_a[n_lines][2],
                    b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7], b[8], b[9], b[10], b[11],
                    b[12], b[13]));
                for (int i = 0; i < 14; i++)
                    byte_a[n_lines][i] = b[i][7:0];
                kind_a[n_lines] = "P";
                n_lines++;
            end else if (line.len() > 0 && line.getc(0) == "F") begin
                void'($sscanf(line, "F %s %d %d %d %d %d", name_a[n_lines],
                    arg_a[n_lines][0], arg_a[n_lines][1], arg_a[n_lines][2],
                    arg_a[n_lines][3], arg_a[n_lines][4]));
                kind_a[n_lines] = "F";
                n_lines++;
            end
        end
    endtask

    task automatic run_vectors();
        for (int i = 0; i < n_lines; i++) begin
            if (kind_a[i] == "F") begin
                run_frame(i);
            end else if (arg_a[i][2] != 0) begin
                mid_idx = i;
            end else begin
                queue_packet(i);
                while (rx_q.size() != 0)
                    step(1'b0, 1'b0, 1'b0, 0, 0);
                repeat (4) step(1'b0, 1'b0, 1'b0, 0, 0);
                close_packet(i);
            end
        end
        repeat (2) step(1'b0, 1'b0, 1'b0, 0, 0);
    endtask

    initial begin
        int fd;
        int limit;
        {cam_sw, draw_sw, rx_valid, rx_data} = '0;
        {c1_hs, c1_vs, c1_de, c1_r, c1_g, c1_b} = '0;
        {c2_hs, c2_vs, c2_de, c2_r, c2_g, c2_b} = '0;
        arst_n   = 1'b0;
        rng      = 32'h7ce6_dd10;
        {sel, vs_last, pend, cam_drv, draw_drv} = '0;
        for (int b = 0; b < `AIM_N_BOX; b++)
            act[b] = '0;
        {n_lines, n_mismatch, n_other, fills, painted} = '0;
        mid_idx  = -1;
        cur_name = "idle";
        fd = $fopen("tests/aim_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file tests/aim_vectors.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            read_vectors(fd);
            $fclose(fd);
            limit = 20;
            for (int i = 0; i < n_lines; i++)
                limit += (kind_a[i] == "F") ?
                    8 + arg_a[i][1] * (arg_a[i][0] + 3) : arg_a[i][0] + 8;
            fork
                begin
                    #(limit * 2 * 4);
                    $display("watchdog expired after %0d cycles, the run did not finish", limit * 2);
                    $display("TEST FAILED");
                    $finish;
                end
            join_none
            repeat (3) @(posedge clk);
            #1 arst_n = 1'b1;
            run_vectors();
            $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
            if (n_mismatch == 0 && n_other == 0 && n_lines > 0)
                $display("TEST PASSED");
            else
                $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// File: compile.f
+incdir+src
src/aim_pkg.sv
src/aim_ifs.sv
src/udp_reader.sv
src/box_decoder.sv
src/box_overlay.sv
src/pack_select.sv
src/aim_overlay_top.sv
tests/tb_clock.sv
tests/aim_props.sv
tests/tb_aim_overlay.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_aim_overlay
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/aim_vectors.txt
# P name len fill mid b0..b13   (mid 1: bytes go out during the next frame)
# F name width height cam_switch draw_switch painted_pixels
F f_none     16 8 0 1 0
P p_two      12 1 0 80 01 00 20 24 06 A0 03 00 60 34 07 00 00
F f_draw     16 8 0 1 66
F f_nodraw   16 8 0 0 0
P p_short    5  0 0 C0 03 00 60 34 00 00 00 00 00 00 00 00 00
F f_short    16 8 0 1 66
P p_long     14 0 0 00 01 00 20 24 06 C0 03 00 60 34 07 11 22
F f_long     16 8 0 1 66
P p_mid      12 1 1 00 01 00 20 24 06 C0 03 00 60 34 07 00 00
F f_midcur   16 8 0 1 66
F f_midnext  16 8 0 1 36
F f_camtog   16 8 1 1 36
F f_cam2     16 8 1 1 36
P p_third    12 1 0 E0 01 00 20 24 06 20 03 00 60 34 07 00 00
F f_back     16 8 0 1 40
F f_cam1     16 8 0 1 40
